// ==== Bender.yml ====
package:
  name: execute_stage

sources:
  - src/execute_pkg.sv
  - src/alu_control.sv
  - src/operand_select.sv
  - src/alu.sv
  - src/execute_stage.sv
  - target: test
    files:
      - tb/execute_assert.sv
      - tb/execute_checker.sv
      - tb/tb_execute_stage.sv

// ==== list.f ====
src/execute_pkg.sv
src/alu_control.sv
src/operand_select.sv
src/alu.sv
src/execute_stage.sv
tb/execute_assert.sv
tb/execute_checker.sv
tb/tb_execute_stage.sv

// ==== src/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu
    import execute_pkg::*;
(
    input  wire alu_op_t i_alu_op,
    input  wire word_t   i_op_a,
    input  wire word_t   i_op_b,
    output ex_out_t      o_out
);

    word_t  result;
    shamt_t sh;
    logic   lt;     // Signed less-than
    logic   eq;

    assign sh = i_op_a[4:0];                        // Value in B shifted by A
    assign lt = $signed(i_op_a) < $signed(i_op_b);
    assign eq = (i_op_a == i_op_b);

    //////////////////////////////////////////////////
    // Operation select
    always_comb begin
        case (i_alu_op)
            ALU_ADD: result = i_op_a + i_op_b;
            ALU_SUB: result = i_op_a - i_op_b;      // Zero on BEQ match
            ALU_AND: result = i_op_a & i_op_b;
            ALU_OR:  result = i_op_a | i_op_b;
            ALU_XOR: result = i_op_a ^ i_op_b;
            ALU_NOR: result = ~(i_op_a | i_op_b);
            ALU_SLT: result = {31'b0, lt};
            ALU_SLL: result = i_op_b << sh;
            ALU_SRL: result = i_op_b >> sh;
            ALU_SRA: result = word_t'($signed(i_op_b) >>> sh);

            // Inverted compare so zero means operands differ
            ALU_BNE: result = {31'b0, eq};

            default: result = i_op_a + i_op_b;
        endcase
    end

    // Zero flag doubles as branch taken for BEQ and BNE
    assign o_out.result = result;
    assign o_out.zero   = (result == '0);

endmodule

`default_nettype wire

// ==== src/alu_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_control
    import execute_pkg::*;
(
    input  wire opcode_t i_opcode,
    input  wire funct_t  i_funct,
    output ex_ctrl_t     o_ctrl
);

    // Fields in order alu_op, shamt_ctrl, imm_sel, imm_zext, lui_sel
    always_comb begin
        o_ctrl = '0;

        case (i_opcode)
            OP_RTYPE: begin
                case (i_funct)
                    FN_ADD:  o_ctrl = '{ALU_ADD, 1'b0, 1'b0, 1'b0, 1'b0};
                    FN_ADDU: o_ctrl = '{ALU_ADD, 1'b0, 1'b0, 1'b0, 1'b0};
                    FN_SUB:  o_ctrl = '{ALU_SUB, 1'b0, 1'b0, 1'b0, 1'b0};
                    FN_SUBU: o_ctrl = '{ALU_SUB, 1'b0, 1'b0, 1'b0, 1'b0};
                    FN_AND:  o_ctrl = '{ALU_AND, 1'b0, 1'b0, 1'b0, 1'b0};
                    FN_OR:   o_ctrl = '{ALU_OR,  1'b0, 1'b0, 1'b0, 1'b0};
                    FN_XOR:  o_ctrl = '{ALU_XOR, 1'b0, 1'b0, 1'b0, 1'b0};
                    FN_NOR:  o_ctrl = '{ALU_NOR, 1'b0, 1'b0, 1'b0, 1'b0};
                    FN_SLT:  o_ctrl = '{ALU_SLT, 1'b0, 1'b0, 1'b0, 1'b0};

                    // Fixed shifts take the shamt field
                    FN_SLL:  o_ctrl = '{ALU_SLL, 1'b1, 1'b0, 1'b0, 1'b0};
                    FN_SRL:  o_ctrl = '{ALU_SRL, 1'b1, 1'b0, 1'b0, 1'b0};
                    FN_SRA:  o_ctrl = '{ALU_SRA, 1'b1, 1'b0, 1'b0, 1'b0};

                    // Variable shifts take rs
                    FN_SLLV: o_ctrl = '{ALU_SLL, 1'b0, 1'b0, 1'b0, 1'b0};
                    FN_SRLV: o_ctrl = '{ALU_SRL, 1'b0, 1'b0, 1'b0, 1'b0};
                    FN_SRAV: o_ctrl = '{ALU_SRA, 1'b0, 1'b0, 1'b0, 1'b0};

                    default: o_ctrl = '{ALU_ADD, 1'b0, 1'b0, 1'b0, 1'b0};
                endcase
            end

            //////////////////////////////////////////////////
            // Sign-extended immediate arithmetic
            OP_ADDI: o_ctrl = '{ALU_ADD, 1'b0, 1'b1, 1'b0, 1'b0};
            OP_SLTI: o_ctrl = '{ALU_SLT, 1'b0, 1'b1, 1'b0, 1'b0};

            // Zero-extended immediate logic
            OP_ANDI: o_ctrl = '{ALU_AND, 1'b0, 1'b1, 1'b1, 1'b0};
            OP_ORI:  o_ctrl = '{ALU_OR,  1'b0, 1'b1, 1'b1, 1'b0};
            OP_XORI: o_ctrl = '{ALU_XOR, 1'b0, 1'b1, 1'b1, 1'b0};

            // LUI runs as imm << 16
            OP_LUI:  o_ctrl = '{ALU_SLL, 1'b0, 1'b1, 1'b1, 1'b1};

            // Branch compare on rs and rt
            OP_BEQ:  o_ctrl = '{ALU_SUB, 1'b0, 1'b0, 1'b0, 1'b0};
            OP_BNE:  o_ctrl = '{ALU_BNE, 1'b0, 1'b0, 1'b0, 1'b0};

            // Address is base plus offset
            OP_LW:   o_ctrl = '{ALU_ADD, 1'b0, 1'b1, 1'b0, 1'b0};
            OP_SW:   o_ctrl = '{ALU_ADD, 1'b0, 1'b1, 1'b0, 1'b0};

            default: o_ctrl = '{ALU_ADD, 1'b0, 1'b0, 1'b0, 1'b0};
        endcase
    end

endmodule

`default_nettype wire

// ==== src/execute_pkg.sv ====
`default_nettype none

package execute_pkg;

    //////////////////////////////////////////////////
    // Field widths
    typedef logic [31:0] word_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [15:0] imm_t;
    typedef logic [3:0]  alu_op_t;

    //////////////////////////////////////////////////
    // ALU operations
    localparam alu_op_t ALU_ADD = 4'd0; // Also the default
    localparam alu_op_t ALU_SUB = 4'd1;
    localparam alu_op_t ALU_AND = 4'd2;
    localparam alu_op_t ALU_OR  = 4'd3;
    localparam alu_op_t ALU_XOR = 4'd4;
    localparam alu_op_t ALU_NOR = 4'd5;
    localparam alu_op_t ALU_SLT = 4'd6;
    localparam alu_op_t ALU_SLL = 4'd7;
    localparam alu_op_t ALU_SRL = 4'd8;
    localparam alu_op_t ALU_SRA = 4'd9;
    localparam alu_op_t ALU_BNE = 4'd10;

    //////////////////////////////////////////////////
    // Opcodes
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_SLTI  = 6'h0a;
    localparam opcode_t OP_ANDI  = 6'h0c;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_XORI  = 6'h0e;
    localparam opcode_t OP_LUI   = 6'h0f;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    // R-type function codes
    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_SRL  = 6'h02;
    localparam funct_t FN_SRA  = 6'h03;
    localparam funct_t FN_SLLV = 6'h04;
    localparam funct_t FN_SRLV = 6'h06;
    localparam funct_t FN_SRAV = 6'h07;
    localparam funct_t FN_ADD  = 6'h20;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUB  = 6'h22;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_NOR  = 6'h27;
    localparam funct_t FN_SLT  = 6'h2a;

    //////////////////////////////////////////////////
    // Pipeline structs
    typedef struct packed {
        opcode_t opcode;
        funct_t  funct;
        shamt_t  shamt;
        imm_t    imm;
        word_t   rs_val;
        word_t   rt_val;
    } ex_in_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    shamt_ctrl; // Shift amount from shamt field
        logic    imm_sel;    // Operand B is the immediate
        logic    imm_zext;
        logic    lui_sel;    // Operand A is 16
    } ex_ctrl_t;

    typedef struct packed {
        word_t result;
        logic  zero;
    } ex_out_t;

endpackage

`default_nettype wire

// ==== src/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage
    import execute_pkg::*;
(
    input  wire          i_clk,
    input  wire          i_rst,
    input  wire logic    i_valid,
    input  wire ex_in_t  i_ex_in,
    output logic         o_valid,
    output ex_out_t      o_ex_out
);

    ex_ctrl_t ctrl;
    word_t    op_a;
    word_t    op_b;
    ex_out_t  alu_out;

    //////////////////////////////////////////////////
    // Combinational execute path
    alu_control alu_control_inst (
        .i_opcode (i_ex_in.opcode),
        .i_funct  (i_ex_in.funct),
        .o_ctrl   (ctrl)
    );

    operand_select operand_select_inst (
        .i_ctrl   (ctrl),
        .i_shamt  (i_ex_in.shamt),
        .i_imm    (i_ex_in.imm),
        .i_rs_val (i_ex_in.rs_val),
        .i_rt_val (i_ex_in.rt_val),
        .o_op_a   (op_a),
        .o_op_b   (op_b)
    );

    alu alu_inst (
        .i_alu_op (ctrl.alu_op),
        .i_op_a   (op_a),
        .i_op_b   (op_b),
        .o_out    (alu_out)
    );

    //////////////////////////////////////////////////
    // EX/MEM register
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid  <= 1'b0;
            o_ex_out <= '0;
        end else begin
            o_valid <= i_valid;
            if (i_valid) begin
                o_ex_out <= alu_out;    // Holds while no new instruction
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/operand_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_select
    import execute_pkg::*;
(
    input  wire ex_ctrl_t i_ctrl,
    input  wire shamt_t   i_shamt,
    input  wire imm_t     i_imm,
    input  wire word_t    i_rs_val,
    input  wire word_t    i_rt_val,
    output word_t         o_op_a,
    output word_t         o_op_b
);

    localparam word_t LUI_SHIFT = 32'd16;

    word_t imm_ext;

    // Zero-extend for logic immediates, sign-extend otherwise
    assign imm_ext = i_ctrl.imm_zext ? {16'b0, i_imm}
                                     : {{16{i_imm[15]}}, i_imm};

    //////////////////////////////////////////////////
    // Operand A
    always_comb begin
        if (i_ctrl.lui_sel) begin
            o_op_a = LUI_SHIFT;
        end else if (i_ctrl.shamt_ctrl) begin
            o_op_a = {27'b0, i_shamt};
        end else begin
            o_op_a = i_rs_val;
        end
    end

    // Operand B
    assign o_op_b = i_ctrl.imm_sel ? imm_ext : i_rt_val;

endmodule

`default_nettype wire

// ==== tb/execute_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_assert (
    input wire       i_clk,
    input wire       i_rst,
    input wire logic i_valid,
    input wire logic i_out_valid
);

    int fail_count = 0;

    // Valid flag clears on a synchronous reset
    reset_clears_valid: assert property (@(posedge i_clk) i_rst |=> !i_out_valid)
        else begin
            fail_count++;
            $error("o_valid high in the cycle after reset");
        end

    valid_follows_input: assert property (@(posedge i_clk)
        !i_rst |=> (i_out_valid == $past(i_valid)))        // One cycle of latency
        else begin
            fail_count++;
            $error("o_valid differs from i_valid of the previous cycle");
        end

endmodule

`default_nettype wire

// ==== tb/execute_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_checker
    import execute_pkg::*;
(
    input  wire          i_clk,
    input  wire          i_rst,
    input  wire logic    i_valid,
    input  wire ex_in_t  i_ex_in,
    input  wire logic    i_out_valid,
    input  wire ex_out_t i_ex_out,
    output int           o_checks,
    output int           o_valid_errs,
    output int           o_data_errs
);

    logic    exp_valid;
    ex_out_t exp_out;
    logic    primed = 1'b0;

    //////////////////////////////////////////////////
    // Expected result per instruction
    function automatic ex_out_t model(input ex_in_t in);
        word_t   rs;
        word_t   rt;
        word_t   sx_imm;
        ex_out_t res;
        rs     = in.rs_val;
        rt     = in.rt_val;
        sx_imm = {{16{in.imm[15]}}, in.imm};
        case (in.opcode)
            OP_RTYPE: case (in.funct)
                FN_ADD, FN_ADDU: res.result = rs + rt;
                FN_SUB, FN_SUBU: res.result = rs - rt;
                FN_AND:  res.result = rs & rt;
                FN_OR:   res.result = rs | rt;
                FN_XOR:  res.result = rs ^ rt;
                FN_NOR:  res.result = ~(rs | rt);
                FN_SLT:  res.result = word_t'($signed(rs) < $signed(rt));
                FN_SLL:  res.result = rt << in.shamt;
                FN_SRL:  res.result = rt >> in.shamt;
                FN_SRA:  res.result = $signed(rt) >>> in.shamt;
                FN_SLLV: res.result = rt << rs[4:0];
                FN_SRLV: res.result = rt >> rs[4:0];
                FN_SRAV: res.result = $signed(rt) >>> rs[4:0];
                default: res.result = rs + rt;              // Unknown function code
            endcase
            OP_ADDI, OP_LW, OP_SW: res.result = rs + sx_imm;
            OP_SLTI: res.result = word_t'($signed(rs) < $signed(sx_imm));
            OP_ANDI: res.result = rs & {16'h0, in.imm};
            OP_ORI:  res.result = rs | {16'h0, in.imm};
            OP_XORI: res.result = rs ^ {16'h0, in.imm};
            OP_LUI:  res.result = {in.imm, 16'h0};
            OP_BEQ:  res.result = rs - rt;
            OP_BNE:  res.result = word_t'(rs == rt);         // Zero when taken
            default: res.result = rs + rt;
        endcase
        res.zero = (res.result == 32'h0);
        return res;
    endfunction

    initial begin
        o_checks     = 0;
        o_valid_errs = 0;
        o_data_errs  = 0;
    end

    // DUT outputs here still hold the previous edge's register value
    always @(posedge i_clk) begin
        if (primed) begin
            if (i_out_valid !== exp_valid) begin
                $display("ERR %0t o_valid exp=%0b got=%0b", $time, exp_valid, i_out_valid);
                o_valid_errs = o_valid_errs + 1;
            end
            if (i_ex_out !== exp_out) begin
                $display("ERR %0t o_ex_out exp=%h,%0b got=%h,%0b", $time,
                         exp_out.result, exp_out.zero, i_ex_out.result, i_ex_out.zero);
                o_data_errs = o_data_errs + 1;
            end
            if (i_out_valid === 1'b1) begin
                o_checks = o_checks + 1;                    // Valid outputs seen
            end
        end
        if (i_rst) begin
            exp_valid = 1'b0;
            exp_out   = '0;
        end else begin
            exp_valid = i_valid;
            if (i_valid) begin
                exp_out = model(i_ex_in);                   // Held otherwise
            end
        end
        primed = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb/tb_execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_execute_stage
    import execute_pkg::*;
();

    localparam int NUM_INSTR   = 2000;
    localparam int DRAIN_LIMIT = 20;

    logic        clk;
    logic        rst;
    logic        valid;
    ex_in_t      ex_in;
    logic        out_valid;
    ex_out_t     ex_out;
    int          checks;
    int          valid_errs;
    int          data_errs;
    int          sent;
    int          n;
    logic        timed_out;
    logic [31:0] rng_state;

    opcode_t itype_ops [10] = '{OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI,
                                OP_LUI, OP_BEQ, OP_BNE, OP_LW, OP_SW};
    funct_t  rtype_fns [15] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR,
                                FN_XOR, FN_NOR, FN_SLT, FN_SLL, FN_SRL, FN_SRA,
                                FN_SLLV, FN_SRLV, FN_SRAV};

    execute_stage execute_stage_inst (
        .i_clk    (clk),
        .i_rst    (rst),
        .i_valid  (valid),
        .i_ex_in  (ex_in),
        .o_valid  (out_valid),
        .o_ex_out (ex_out)
    );

    execute_checker execute_checker_inst (
        .i_clk        (clk),
        .i_rst        (rst),
        .i_valid      (valid),
        .i_ex_in      (ex_in),
        .i_out_valid  (out_valid),
        .i_ex_out     (ex_out),
        .o_checks     (checks),
        .o_valid_errs (valid_errs),
        .o_data_errs  (data_errs)
    );

    bind execute_stage execute_assert execute_assert_inst (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_valid     (i_valid),
        .i_out_valid (o_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    //////////////////////////////////////////////////
    // Random instruction with about three in four valid
    task automatic drive_random_instr();
        logic [31:0] r;
        r = next_rand();
        if (r[3:0] < 4) begin
            ex_in.opcode = OP_RTYPE;
        end else if (r[3:0] < 14) begin
            ex_in.opcode = itype_ops[r[3:0] - 4];
        end else begin
            ex_in.opcode = r[9:4];                          // Mostly unknown
        end
        ex_in.funct = (r[14:10] < 15) ? rtype_fns[r[14:10]] : r[31:26];
        ex_in.shamt = r[20:16];
        r = next_rand();
        ex_in.imm    = r[15:0];
        valid        = (r[17:16] != 2'b00);
        ex_in.rs_val = next_rand();
        ex_in.rt_val = (r[19:18] == 2'b00) ? ex_in.rs_val : next_rand();  // Branch hits
        sent = sent + int'(valid);
    endtask

    initial begin
        rng_state = 32'hb63a;
        rst       = 1'b1;
        valid     = 1'b0;
        ex_in     = '0;
        sent      = 0;
        timed_out = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        for (n = 0; n < NUM_INSTR; n++) begin
            drive_random_instr();
            @(posedge clk);
            #1;
        end
        valid = 1'b0;

        // Drain until the DUT has returned every valid instruction
        n = 0;
        while (checks < sent && n < DRAIN_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (checks < sent) begin
            timed_out = 1'b1;
            $display("Timeout: only %0d of %0d valid instructions came out", checks, sent);
        end
        $display("Errors: valid %0d, data %0d, assertion %0d (checked %0d)", valid_errs,
                 data_errs, execute_stage_inst.execute_assert_inst.fail_count, checks);
        if (valid_errs == 0 && data_errs == 0 && !timed_out &&
            execute_stage_inst.execute_assert_inst.fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
